// File: osiris_pkg.sv
`default_nettype none

package osiris_pkg;

    // ----------------------------------------
    // Bus and memory geometry
    // ----------------------------------------
    localparam int DATA_WIDTH     = 32;    // Word width of every bus
    localparam int MEM_ADDR_WIDTH = 10;    // Word index into either memory
    localparam int INST_MEM_WORDS = 1024;  // Instruction memory depth
    localparam int DATA_MEM_WORDS = 1024;  // Data memory depth

    // ----------------------------------------
    // UART timing
    // ----------------------------------------
    // Short bit period keeps simulation runs quick
    localparam int CLKS_PER_BIT = 16;

    // ----------------------------------------
    // Loader command codes
    // ----------------------------------------
    localparam logic [7:0] CMD_READ  = 8'h01;  // Read word, reply with 4 bytes
    localparam logic [7:0] CMD_WRITE = 8'hAA;  // Write word, no reply

endpackage

`default_nettype wire

// File: uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx import osiris_pkg::*; (
    input  logic       clk,
    input  logic       rst_i,
    input  logic       rx_i,     // Serial line, idles high
    output logic [7:0] data_o,   // Last received byte
    output logic       valid_o   // One-cycle pulse per good frame
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t        state_q;
    logic [1:0]       sync_q;    // Two-flop synchronizer
    logic [CNT_W-1:0] clk_cnt_q; // Cycles inside current bit
    logic [2:0]       bit_cnt_q; // Data bit index
    logic [7:0]       shift_q;
    logic             bit_tick;  // Middle of a data or stop bit
    logic             half_tick; // Middle of the start bit
    logic             rx_s;

    assign rx_s      = sync_q[1];
    assign bit_tick  = (clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1));
    assign half_tick = (clk_cnt_q == CNT_W'(CLKS_PER_BIT / 2 - 1));
    assign data_o    = shift_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            sync_q    <= 2'b11; // Line idles high
            state_q   <= RX_IDLE;
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            valid_o   <= 1'b0;
        end else begin
            sync_q  <= {sync_q[0], rx_i};
            valid_o <= 1'b0;
            clk_cnt_q <= clk_cnt_q + 1'b1;
            case (state_q)
                RX_IDLE: begin
                    clk_cnt_q <= '0;
                    if (!rx_s) state_q <= RX_START; // Falling edge of start bit
                end
                RX_START: if (half_tick) begin
                    clk_cnt_q <= '0;
                    bit_cnt_q <= '0;
                    state_q   <= rx_s ? RX_IDLE : RX_DATA; // Glitch filter
                end
                RX_DATA: if (bit_tick) begin
                    clk_cnt_q <= '0;
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                    if (bit_cnt_q == 3'd7) state_q <= RX_STOP;
                end
                RX_STOP: if (bit_tick) begin
                    valid_o <= rx_s;    // Framing error drops the byte
                    state_q <= RX_IDLE;
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state_q == RX_DATA && bit_tick) shift_q <= {rx_s, shift_q[7:1]};
    end

endmodule

`default_nettype wire

// File: uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx import osiris_pkg::*; (
    input  logic       clk,
    input  logic       rst_i,
    input  logic [7:0] data_i,   // Byte to send
    input  logic       start_i,  // Load pulse, honoured only when idle
    output logic       tx_o,     // Serial line
    output logic       busy_o    // High for 10 bit times per frame
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    logic [9:0]       frame_q;   // Stop, data, start; bit 0 goes out first
    logic [CNT_W-1:0] clk_cnt_q;
    logic [3:0]       bit_cnt_q;
    logic             bit_tick;

    assign bit_tick = (clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1));
    assign tx_o     = busy_o ? frame_q[0] : 1'b1; // Idle line is high

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_o    <= 1'b0;
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
        end else if (!busy_o) begin
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            if (start_i) busy_o <= 1'b1;
        end else if (bit_tick) begin
            clk_cnt_q <= '0;
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 4'd9) busy_o <= 1'b0; // Stop bit done
        end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy_o && start_i) frame_q <= {1'b1, data_i, 1'b0};
        else if (busy_o && bit_tick) frame_q <= {1'b1, frame_q[9:1]};
    end

    // Controller must wait for busy to drop before the next byte
    a_no_start_busy: assert property (@(posedge clk) disable iff (rst_i)
        busy_o |-> !start_i);

endmodule

`default_nettype wire

// File: uart_cmd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_ctrl import osiris_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      rx_enable_i, // Gate for incoming bytes
    input  logic [7:0]                rx_data_i,
    input  logic                      rx_valid_i,
    input  logic                      tx_busy_i,
    output logic [7:0]                tx_data_o,
    output logic                      tx_start_o,
    output logic                      ld_stb_o,    // Held until ld_ack_i
    output logic                      ld_we_o,
    output logic [MEM_ADDR_WIDTH-1:0] ld_addr_o,
    output logic [DATA_WIDTH-1:0]     ld_wdata_o,
    input  logic                      ld_ack_i,
    input  logic [DATA_WIDTH-1:0]     ld_rdata_i
);

    typedef enum logic [2:0] {S_IDLE, S_ADDR, S_DATA, S_MEM, S_REPLY} state_t;

    state_t                state_q;
    logic [2:0]            byte_cnt_q;  // Field bytes taken, or reply bytes started
    logic                  is_write_q;
    logic [DATA_WIDTH-1:0] reply_q;     // Read word, MSB byte at the top
    logic                  rx_take;     // Byte accepted this cycle
    logic                  field_last;  // Fourth byte of address or data field
    logic                  tx_go;       // Launch next reply byte

    assign rx_take    = rx_valid_i && rx_enable_i;
    assign field_last = rx_take && (byte_cnt_q == 3'd3);
    assign tx_go      = (state_q == S_REPLY) && !tx_busy_i && !tx_start_o
                        && (byte_cnt_q != 3'd4);
    assign ld_we_o    = is_write_q; // Stable for the whole command

    // ----------------------------------------
    // Command FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q    <= S_IDLE;
            byte_cnt_q <= '0;
            is_write_q <= 1'b0;
            ld_stb_o   <= 1'b0;
            tx_start_o <= 1'b0;
        end else begin
            tx_start_o <= 1'b0; // Single-cycle pulse
            case (state_q)
                S_IDLE: begin
                    byte_cnt_q <= '0;
                    // Unknown codes fall through and are dropped
                    if (rx_take && (rx_data_i == CMD_READ || rx_data_i == CMD_WRITE)) begin
                        is_write_q <= (rx_data_i == CMD_WRITE);
                        state_q    <= S_ADDR;
                    end
                end
                S_ADDR: if (rx_take) begin
                    byte_cnt_q <= field_last ? 3'd0 : byte_cnt_q + 1'b1;
                    if (field_last && is_write_q) begin
                        state_q <= S_DATA;
                    end else if (field_last) begin
                        state_q  <= S_MEM;
                        ld_stb_o <= 1'b1; // Read goes straight to memory
                    end
                end
                S_DATA: if (rx_take) begin
                    byte_cnt_q <= field_last ? 3'd0 : byte_cnt_q + 1'b1;
                    if (field_last) begin
                        state_q  <= S_MEM;
                        ld_stb_o <= 1'b1;
                    end
                end
                S_MEM: if (ld_ack_i) begin
                    ld_stb_o <= 1'b0;                          // Drop on the next edge
                    state_q  <= is_write_q ? S_IDLE : S_REPLY; // Writes stay silent
                end
                S_REPLY: begin
                    if (tx_go) begin
                        tx_start_o <= 1'b1;
                        byte_cnt_q <= byte_cnt_q + 1'b1;
                    end else if (byte_cnt_q == 3'd4 && !tx_busy_i && !tx_start_o) begin
                        state_q <= S_IDLE; // Last frame fully on the line
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // Field and reply shift registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        // Only the low word-index bits of the 32-bit address survive
        if (state_q == S_ADDR && rx_take)
            ld_addr_o <= {ld_addr_o[MEM_ADDR_WIDTH-9:0], rx_data_i};
        if (state_q == S_DATA && rx_take)
            ld_wdata_o <= {ld_wdata_o[DATA_WIDTH-9:0], rx_data_i};
        if (state_q == S_MEM && ld_ack_i) begin
            reply_q <= ld_rdata_i; // Memory output moves on once the loader lets go
        end else if (tx_go) begin
            tx_data_o <= reply_q[DATA_WIDTH-1 -: 8]; // MSB first
            reply_q   <= reply_q << 8;
        end
    end

    // Strobe holds, with a steady request, until the memory answers
    a_stb_hold: assert property (@(posedge clk) disable iff (rst_i)
        ld_stb_o && !ld_ack_i |=> ld_stb_o && $stable(ld_addr_o) && $stable(ld_we_o));

    // Memory answers on the edge after the strobe rises
    a_ack_latency: assert property (@(posedge clk) disable iff (rst_i)
        $rose(ld_stb_o) |=> ld_ack_i);

endmodule

`default_nettype wire

// File: mem_port_mux.sv
`timescale 1ns/1ps
`default_nettype none

module mem_port_mux import osiris_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      select_mem_i,     // 0 instruction, 1 data
    // Loader side
    input  logic                      ld_stb_i,
    input  logic                      ld_we_i,
    input  logic [MEM_ADDR_WIDTH-1:0] ld_addr_i,
    input  logic [DATA_WIDTH-1:0]     ld_wdata_i,
    output logic                      ld_ack_o,
    output logic [DATA_WIDTH-1:0]     ld_rdata_o,
    // Core side
    input  logic [MEM_ADDR_WIDTH-1:0] core_pc_i,
    input  logic [MEM_ADDR_WIDTH-1:0] core_data_addr_i,
    input  logic                      core_data_we_i,
    input  logic [DATA_WIDTH-1:0]     core_wdata_i,
    output logic [DATA_WIDTH-1:0]     core_instr_o,
    output logic [DATA_WIDTH-1:0]     core_rdata_o,
    output logic                      core_stall_o,
    // Instruction memory
    output logic                      im_stb_o,
    output logic                      im_we_o,
    output logic [MEM_ADDR_WIDTH-1:0] im_addr_o,
    output logic [DATA_WIDTH-1:0]     im_wdata_o,
    input  logic                      im_ack_i,
    input  logic [DATA_WIDTH-1:0]     im_rdata_i,
    // Data memory
    output logic                      dm_stb_o,
    output logic                      dm_we_o,
    output logic [MEM_ADDR_WIDTH-1:0] dm_addr_o,
    output logic [DATA_WIDTH-1:0]     dm_wdata_o,
    input  logic                      dm_ack_i,
    input  logic [DATA_WIDTH-1:0]     dm_rdata_i
);

    logic ld_own_q; // Loader cycle already running
    logic sel_q;    // Target latched at strobe start
    logic ld_tgt;   // 1 when the loader targets the data memory
    logic ld_im;
    logic ld_dm;

    // First strobe cycle takes the live select, later cycles the latched one
    assign ld_tgt = ld_own_q ? sel_q : select_mem_i;
    assign ld_im  = ld_stb_i && !ld_tgt;
    assign ld_dm  = ld_stb_i && ld_tgt;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ld_own_q <= 1'b0;
            sel_q    <= 1'b0;
        end else begin
            ld_own_q <= ld_stb_i;
            if (ld_stb_i) sel_q <= ld_tgt;
        end
    end

    // Core waits out any loader cycle, whichever memory it hits
    assign core_stall_o = ld_stb_i;

    // ----------------------------------------
    // Instruction memory, core only fetches
    // ----------------------------------------
    assign im_stb_o   = ld_im;
    assign im_we_o    = ld_im && ld_we_i;
    assign im_addr_o  = ld_im ? ld_addr_i : core_pc_i;
    assign im_wdata_o = ld_wdata_i;

    // ----------------------------------------
    // Data memory, core reads and writes
    // ----------------------------------------
    assign dm_stb_o   = ld_dm;
    assign dm_we_o    = ld_dm ? ld_we_i : (core_data_we_i && !core_stall_o);
    assign dm_addr_o  = ld_dm ? ld_addr_i : core_data_addr_i;
    assign dm_wdata_o = ld_dm ? ld_wdata_i : core_wdata_i;

    // Returns to both masters
    assign ld_ack_o     = ld_tgt ? dm_ack_i : im_ack_i;
    assign ld_rdata_o   = ld_tgt ? dm_rdata_i : im_rdata_i;
    assign core_instr_o = im_rdata_i;
    assign core_rdata_o = dm_rdata_i;

    // A loader write keeps the instruction memory until its ack
    a_im_we_loader: assert property (@(posedge clk) disable iff (rst_i)
        im_we_o && !im_ack_i |=> im_we_o);

endmodule

`default_nettype wire

// File: wb_mem.sv
`timescale 1ns/1ps
`default_nettype none

module wb_mem import osiris_pkg::*; #(
    parameter int MEM_WORDS = 1024  // Up to 2**MEM_ADDR_WIDTH
) (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      stb_i,   // Loader access request
    input  logic                      we_i,
    input  logic [MEM_ADDR_WIDTH-1:0] addr_i,
    input  logic [DATA_WIDTH-1:0]     wdata_i,
    output logic [DATA_WIDTH-1:0]     rdata_o, // Registered, one cycle behind addr_i
    output logic                      ack_o    // One pulse per strobed access
);

    logic [DATA_WIDTH-1:0] mem_q [MEM_WORDS];
    logic                  wr_en;

    // Strobed write on its first cycle, or an unstrobed core write
    assign wr_en = we_i && (stb_i ? !ack_o : 1'b1);

    always_ff @(posedge clk) begin
        if (wr_en) mem_q[addr_i] <= wdata_i;
        rdata_o <= mem_q[addr_i]; // Read every cycle, old data on a write
    end

    always_ff @(posedge clk) begin
        if (rst_i) ack_o <= 1'b0;
        else       ack_o <= stb_i && !ack_o; // Never two acks in a row
    end

endmodule

`default_nettype wire

// File: osiris_soc.sv
`timescale 1ns/1ps
`default_nettype none

module osiris_soc import osiris_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      uart_rx_i,
    output logic                      uart_tx_o,
    input  logic                      rx_enable_i,      // Lets loader commands in
    input  logic                      select_mem_i,     // 0 instruction, 1 data
    input  logic [MEM_ADDR_WIDTH-1:0] core_pc_i,
    output logic [DATA_WIDTH-1:0]     core_instr_o,
    input  logic [MEM_ADDR_WIDTH-1:0] core_data_addr_i,
    input  logic                      core_data_we_i,
    input  logic [DATA_WIDTH-1:0]     core_wdata_i,
    output logic [DATA_WIDTH-1:0]     core_rdata_o,
    output logic                      core_stall_o      // Loader owns a memory
);

    // ----------------------------------------
    // UART byte links
    // ----------------------------------------
    logic [7:0] rx_data;
    logic       rx_valid;
    logic [7:0] tx_data;
    logic       tx_start;
    logic       tx_busy;

    // ----------------------------------------
    // Loader bus and memory ports
    // ----------------------------------------
    logic                      ld_stb, ld_we, ld_ack;
    logic [MEM_ADDR_WIDTH-1:0] ld_addr;
    logic [DATA_WIDTH-1:0]     ld_wdata, ld_rdata;
    logic                      im_stb, im_we, im_ack;
    logic [MEM_ADDR_WIDTH-1:0] im_addr;
    logic [DATA_WIDTH-1:0]     im_wdata, im_rdata;
    logic                      dm_stb, dm_we, dm_ack;
    logic [MEM_ADDR_WIDTH-1:0] dm_addr;
    logic [DATA_WIDTH-1:0]     dm_wdata, dm_rdata;

    uart_rx u_uart_rx (
        .clk, .rst_i, .rx_i(uart_rx_i), .data_o(rx_data), .valid_o(rx_valid)
    );

    uart_tx u_uart_tx (
        .clk, .rst_i, .data_i(tx_data), .start_i(tx_start),
        .tx_o(uart_tx_o), .busy_o(tx_busy)
    );

    uart_cmd_ctrl u_cmd_ctrl (
        .clk, .rst_i, .rx_enable_i,
        .rx_data_i(rx_data), .rx_valid_i(rx_valid), .tx_busy_i(tx_busy),
        .tx_data_o(tx_data), .tx_start_o(tx_start),
        .ld_stb_o(ld_stb), .ld_we_o(ld_we), .ld_addr_o(ld_addr), .ld_wdata_o(ld_wdata),
        .ld_ack_i(ld_ack), .ld_rdata_i(ld_rdata)
    );

    mem_port_mux u_port_mux (
        .clk, .rst_i, .select_mem_i,
        .ld_stb_i(ld_stb), .ld_we_i(ld_we), .ld_addr_i(ld_addr), .ld_wdata_i(ld_wdata),
        .ld_ack_o(ld_ack), .ld_rdata_o(ld_rdata),
        .core_pc_i, .core_data_addr_i, .core_data_we_i, .core_wdata_i,
        .core_instr_o, .core_rdata_o, .core_stall_o,
        .im_stb_o(im_stb), .im_we_o(im_we), .im_addr_o(im_addr), .im_wdata_o(im_wdata),
        .im_ack_i(im_ack), .im_rdata_i(im_rdata),
        .dm_stb_o(dm_stb), .dm_we_o(dm_we), .dm_addr_o(dm_addr), .dm_wdata_o(dm_wdata),
        .dm_ack_i(dm_ack), .dm_rdata_i(dm_rdata)
    );

    wb_mem #(.MEM_WORDS(INST_MEM_WORDS)) inst_mem ( // Program store
        .clk, .rst_i, .stb_i(im_stb), .we_i(im_we), .addr_i(im_addr),
        .wdata_i(im_wdata), .rdata_o(im_rdata), .ack_o(im_ack)
    );

    wb_mem #(.MEM_WORDS(DATA_MEM_WORDS)) data_mem ( // Load/store space
        .clk, .rst_i, .stb_i(dm_stb), .we_i(dm_we), .addr_i(dm_addr),
        .wdata_i(dm_wdata), .rdata_o(dm_rdata), .ack_o(dm_ack)
    );

endmodule

`default_nettype wire

// File: tb_uart_tasks.svh
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

// Command byte, address and optional data go out MSB first
task automatic send_command(input logic [7:0] cmd, input logic [31:0] addr,
                            input logic [31:0] data, input logic with_data);
    logic [71:0] stream;
    logic [9:0]  frame;
    stream = {cmd, addr, data};
    for (int i = 0; i < (with_data ? 9 : 5); i++) begin
        frame = {1'b1, stream[71 - 8*i -: 8], 1'b0}; // Stop, byte, start
        for (int b = 0; b < 10; b++) begin
            uart_rx_i = frame[b];                    // LSB of the frame first
            repeat (CLKS_PER_BIT) @(posedge clk);
            #1;
        end
    end
endtask

// Four reply frames make one word, MSB byte first
task automatic receive_word(output logic [31:0] word);
    logic [7:0] cur;
    word = '0;
    for (int n = 0; n < 4; n++) begin
        while (uart_tx_o !== 1'b0) @(negedge clk);   // Wait for start bit
        repeat (CLKS_PER_BIT / 2) @(negedge clk);    // Middle of start bit
        if (uart_tx_o !== 1'b0) begin
            $display("Start bit on uart_tx_o did not stay low");
            abort_run();
        end
        for (int b = 0; b < 8; b++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            cur[b] = uart_tx_o;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        if (uart_tx_o !== 1'b1) begin
            $display("Stop bit on uart_tx_o was not high");
            abort_run();
        end
        word = {word[23:0], cur};
    end
endtask

`endif

// File: tb_osiris_soc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_osiris_soc import osiris_pkg::*; ();

    localparam int     N_WORDS     = 4;   // Random words per behavior
    // Nine bytes per command, read reply included
    localparam int     TOTAL_BYTES = (6 * N_WORDS + 6) * 9;
    localparam longint WATCHDOG_NS = longint'(TOTAL_BYTES) * 10 * CLKS_PER_BIT * 100 * 2
                                     + 1_000_000;

    logic                      clk, rst_i, uart_rx_i, uart_tx_o, rx_enable_i, select_mem_i;
    logic [MEM_ADDR_WIDTH-1:0] core_pc_i, core_data_addr_i;
    logic                      core_data_we_i, core_stall_o;
    logic [DATA_WIDTH-1:0]     core_wdata_i, core_instr_o, core_rdata_o;

    logic [DATA_WIDTH-1:0] ref_im [INST_MEM_WORDS]; // Model of both memories
    logic [DATA_WIDTH-1:0] ref_dm [DATA_MEM_WORDS];
    logic [DATA_WIDTH-1:0] exp_q [$];                // Replies still awaited
    logic [31:0]           im_addrs [N_WORDS];       // Loaded fetch addresses
    int                    reply_count = 0;
    logic                  stall_seen;
    integer                seed;

    osiris_soc DUT (.*);

    always #50 clk = ~clk; // 100 ns period

    always @(negedge clk) if (core_stall_o === 1'b1) stall_seen = 1'b1;

    function automatic logic [DATA_WIDTH-1:0] expected_word(input logic sel,
                                                            input logic [31:0] addr);
        return sel ? ref_dm[addr[MEM_ADDR_WIDTH-1:0]] : ref_im[addr[MEM_ADDR_WIDTH-1:0]];
    endfunction

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: actual 0x%h expected 0x%h", name, actual, expected);
            abort_run();
        end
    endtask

    `include "tb_uart_tasks.svh"

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #1;                          // Drive just after the edge
    endtask

    task automatic loader_write(input logic sel, input logic [31:0] addr,
                                input logic [31:0] data);
        select_mem_i = sel;
        send_command(CMD_WRITE, addr, data, 1'b1);
        if (sel) ref_dm[addr[MEM_ADDR_WIDTH-1:0]] = data;
        else     ref_im[addr[MEM_ADDR_WIDTH-1:0]] = data;
    endtask

    task automatic loader_read_check(input logic sel, input logic [31:0] addr);
        int target;
        select_mem_i = sel;
        target = reply_count + 1;
        exp_q.push_back(expected_word(sel, addr));
        send_command(CMD_READ, addr, '0, 1'b0);
        while (reply_count < target) @(posedge clk); // Watchdog bounds this
        #1;
    endtask

    // ----------------------------------------
    // Reply checker and watchdog
    // ----------------------------------------
    initial begin : reply_checker
        logic [DATA_WIDTH-1:0] word;
        forever begin
            receive_word(word);
            if (exp_q.size() == 0) begin
                $display("Reply word 0x%h arrived on uart_tx_o without a read", word);
                abort_run();
            end
            check_value("uart_tx_o reply", word, exp_q.pop_front());
            reply_count++;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the test did not finish in the allowed time");
        abort_run();
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin : main_sequence
        logic [31:0] addr;
        logic [31:0] word;
        seed = 12;
        clk = 1'b0;
        rst_i = 1'b1;
        uart_rx_i = 1'b1;            // Idle line
        rx_enable_i = 1'b1;
        select_mem_i = 1'b0;
        core_pc_i = '0;
        core_data_addr_i = '0;
        core_data_we_i = 1'b0;
        core_wdata_i = '0;
        stall_seen = 1'b0;
        step(3);
        rst_i = 1'b0;
        step(2);
        check_value("uart_tx_o", 32'(uart_tx_o), 32'h1);
        check_value("core_stall_o", 32'(core_stall_o), 32'h0);
        for (int i = 0; i < N_WORDS; i++) begin // Instruction memory over UART
            im_addrs[i] = $random(seed);
            loader_write(1'b0, im_addrs[i], $random(seed));
            loader_read_check(1'b0, im_addrs[i]);
        end
        for (int i = 0; i < N_WORDS; i++) begin // Data memory over UART
            addr = $random(seed);
            loader_write(1'b1, addr, $random(seed));
            loader_read_check(1'b1, addr);
        end
        for (int i = 0; i < N_WORDS; i++) loader_read_check(1'b0, im_addrs[i]);
        for (int i = 0; i < N_WORDS; i++) begin // Core fetch, one cycle latency
            core_pc_i = im_addrs[i][MEM_ADDR_WIDTH-1:0];
            step(1);
            check_value("core_instr_o", core_instr_o, expected_word(1'b0, im_addrs[i]));
        end
        for (int i = 0; i < N_WORDS; i++) begin // Core write, then read both ways
            addr = $random(seed);
            word = $random(seed);
            core_data_addr_i = addr[MEM_ADDR_WIDTH-1:0];
            core_wdata_i = word;
            core_data_we_i = 1'b1;
            step(1);
            core_data_we_i = 1'b0;
            ref_dm[addr[MEM_ADDR_WIDTH-1:0]] = word;
            step(1);
            check_value("core_rdata_o", core_rdata_o, word);
            loader_read_check(1'b1, addr);
        end
        word = $random(seed);                    // Gated and unknown commands
        loader_write(1'b0, 32'h0, word);
        rx_enable_i = 1'b0;
        send_command(CMD_WRITE, 32'h0, ~word, 1'b1);
        rx_enable_i = 1'b1;
        send_command(8'h55, 32'h0, 32'h5555_5555, 1'b1); // No byte is a valid code
        loader_read_check(1'b0, 32'h0);
        addr = $random(seed);                    // Core write held across a loader write
        select_mem_i = 1'b1;
        core_data_addr_i = addr[MEM_ADDR_WIDTH-1:0];
        core_wdata_i = $random(seed);
        core_data_we_i = 1'b1;
        stall_seen = 1'b0;
        send_command(CMD_WRITE, addr, $random(seed), 1'b1);
        step(2);                                 // Core writes again once released
        core_data_we_i = 1'b0;
        ref_dm[addr[MEM_ADDR_WIDTH-1:0]] = core_wdata_i;
        check_value("core_stall_o seen high", 32'(stall_seen), 32'h1);
        loader_read_check(1'b1, addr);
        if (exp_q.size() != 0) begin
            $display("Read replies were still outstanding at the end of the test");
            abort_run();
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
osiris_pkg.sv
uart_rx.sv
uart_tx.sv
uart_cmd_ctrl.sv
mem_port_mux.sv
wb_mem.sv
osiris_soc.sv
tb_osiris_soc.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_osiris_soc -f project.f

output=$(./obj_dir/Vtb_osiris_soc 2>&1 || true)
echo "$output"

if echo "$output" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
exit 1
